// ==== arrayHeap.f ====
+incdir+common
+incdir+dv
common/arrayHeapPkg.sv
decode/requestDecode.sv
decode/arrayDirectory.sv
execute/elementStore.sv
execute/elementAlu.sv
execute/arraySearch.sv
result/resultStage.sv
logic/arrayHeap.sv
dv/arrayHeapTb.sv

// ==== common/arrayHeapPkg.sv ====
// --------------------------------------
// Shared types for the array heap
// Import into any module that carries
// requests, responses or rows
// --------------------------------------
`default_nettype none
`include "arrayHeap_cfg.svh"

package arrayHeapPkg;

  typedef logic [`HEAP_ARRAY_BITS-1:0] arrayIdT;  // Array number
  typedef logic [`HEAP_INDEX_BITS-1:0] indexT;    // Element index
  typedef logic [`HEAP_INDEX_BITS:0]   sizeT;     // Size, one bit wider than an index
  typedef logic [`HEAP_DATA_BITS-1:0]  dataT;     // Element word
  typedef dataT [`HEAP_LENGTH-1:0]     rowT;      // All elements of one array

  typedef enum logic [7:0] {
    actIdle       = 8'd0,
    actReset      = 8'd1,                         // Forget every array
    actWrite      = 8'd2,
    actRead       = 8'd3,
    actSize       = 8'd4,
    actIndex      = 8'd7,                         // Last match plus one
    actLess       = 8'd8,
    actGreater    = 8'd9,
    actPush       = 8'd14,
    actPop        = 8'd15,
    actAlloc      = 8'd18,
    actFree       = 8'd19,
    actAdd        = 8'd20,
    actAddAfter   = 8'd21,                        // Returns old value
    actSubtract   = 8'd22,
    actSubAfter   = 8'd23,                        // Returns old value
    actShiftLeft  = 8'd24,
    actShiftRight = 8'd25,
    actNotLogical = 8'd26,
    actNot        = 8'd27,
    actOr         = 8'd28,
    actXor        = 8'd29,
    actAnd        = 8'd30
  } actionT;

  typedef enum logic [2:0] {
    errNone,
    errNotAllocated,                              // Never handed out
    errFreed,                                     // Handed out then freed
    errOutOfBounds,
    errFull,
    errEmpty,
    errOutOfMemory
  } heapErrorT;

  typedef struct packed {
    actionT  action;
    arrayIdT arrayId;
    indexT   index;
    dataT    data;
  } heapRequestT;

  typedef struct packed {
    actionT    action;
    arrayIdT   arrayId;
    indexT     index;
    dataT      data;
    heapErrorT fault;                             // First failed check
    logic      commit;                            // Request changes state
    sizeT      size;                              // Size of the named array
  } decodedT;

  typedef struct packed {
    logic      done;                              // One cycle per action
    dataT      data;
    heapErrorT error;
  } heapResponseT;

endpackage

`default_nettype wire

// ==== common/arrayHeap_cfg.svh ====
// --------------------------------------
// Size settings for the array heap
// Included by the package and by modules
// that need array counts or lengths
// --------------------------------------
`ifndef ARRAY_HEAP_CFG_SVH
`define ARRAY_HEAP_CFG_SVH

// --------------------------------------
// Widths
// --------------------------------------
`define HEAP_ARRAY_BITS 3                        // Bits in an array number
`define HEAP_INDEX_BITS 3                        // Bits in an element index
`define HEAP_DATA_BITS  16                       // Element width

// --------------------------------------
// Derived counts
// --------------------------------------
`define HEAP_ARRAYS (1 << `HEAP_ARRAY_BITS)      // Arrays in the heap
`define HEAP_LENGTH (1 << `HEAP_INDEX_BITS)      // Elements per array

`endif

// ==== decode/arrayDirectory.sv ====
// --------------------------------------
// Allocation directory
// Per-array sizes and flags, LIFO free
// stack and fresh array counter
// --------------------------------------
`default_nettype none
`include "arrayHeap_cfg.svh"

module arrayDirectory import arrayHeapPkg::*; (
  input  logic    clock,
  input  logic    resetN,
  input  arrayIdT lookupId,
  input  decodedT decoded,
  output sizeT    arraySize,
  output logic    allocated,
  output logic    everIssued,
  output logic    canAlloc,
  output arrayIdT allocId
);

  localparam logic [`HEAP_ARRAY_BITS:0] AllArrays = `HEAP_ARRAYS;

  sizeT                      sizes     [`HEAP_ARRAYS];
  logic [`HEAP_ARRAYS-1:0]   allocFlags;                 // Live arrays
  arrayIdT                   freeStack [`HEAP_ARRAYS];   // Freed arrays, top is newest
  logic [`HEAP_ARRAY_BITS:0] freeTop;                    // Entries on the free stack
  logic [`HEAP_ARRAY_BITS:0] freshCount;                 // Arrays ever handed out
  logic                      haveFreed;

  assign haveFreed  = freeTop != '0;
  assign arraySize  = sizes[lookupId];
  assign allocated  = allocFlags[lookupId];
  assign everIssued = {1'b0, lookupId} < freshCount;
  assign canAlloc   = haveFreed || freshCount != AllArrays;
  assign allocId    = haveFreed ? freeStack[freeTop[`HEAP_ARRAY_BITS-1:0] - 1'b1]
                                : freshCount[`HEAP_ARRAY_BITS-1:0];

  // --------------------------------------
  // Control state
  // --------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocFlags <= '0;
      freeTop    <= '0;
      freshCount <= '0;
      for (int i = 0; i < `HEAP_ARRAYS; i++) begin
        sizes[i] <= '0;
      end
    end else if (decoded.commit) begin
      case (decoded.action)
        actReset: begin
          allocFlags <= '0;                              // Every array becomes unissued
          freeTop    <= '0;
          freshCount <= '0;
          for (int i = 0; i < `HEAP_ARRAYS; i++) begin
            sizes[i] <= '0;
          end
        end
        actAlloc: begin
          if (haveFreed) freeTop <= freeTop - 1'b1;      // Reuse newest freed
          else freshCount <= freshCount + 1'b1;
          allocFlags[allocId] <= 1'b1;
          sizes[allocId]      <= '0;
        end
        actFree: begin
          freeTop                     <= freeTop + 1'b1;
          allocFlags[decoded.arrayId] <= 1'b0;           // Own flag, not the stack slot
        end
        actWrite: begin
          if ({1'b0, decoded.index} >= decoded.size) begin
            sizes[decoded.arrayId] <= {1'b0, decoded.index} + 1'b1;
          end
        end
        actPush: sizes[decoded.arrayId] <= decoded.size + 1'b1;
        actPop:  sizes[decoded.arrayId] <= decoded.size - 1'b1;
        default: ;
      endcase
    end
  end

  // Free stack payload, pushed on Free
  always_ff @(posedge clock) begin
    if (decoded.commit && decoded.action == actFree) begin
      freeStack[freeTop[`HEAP_ARRAY_BITS-1:0]] <= decoded.arrayId;
    end
  end

endmodule

`default_nettype wire

// ==== decode/requestDecode.sv ====
// --------------------------------------
// Request checks
// Finds the first fault of a request and
// whether it may change state
// --------------------------------------
`default_nettype none
`include "arrayHeap_cfg.svh"

module requestDecode import arrayHeapPkg::*; (
  input  heapRequestT request,
  input  sizeT        arraySize,
  input  logic        allocated,
  input  logic        everIssued,
  input  logic        canAlloc,
  output decodedT     decoded
);

  localparam sizeT FullSize = `HEAP_LENGTH;        // Size of a full array

  logic      checkAlloc;                           // Array must be live
  logic      checkBounds;                          // Index must be below size
  heapErrorT fault;

  // Kind of check per action
  always_comb begin
    checkAlloc  = 1'b1;
    checkBounds = 1'b0;
    case (request.action)
      actIdle, actReset, actAlloc: checkAlloc = 1'b0;   // Directory actions
      actRead, actAdd, actAddAfter, actSubtract, actSubAfter,
      actShiftLeft, actShiftRight, actNotLogical, actNot,
      actOr, actXor, actAnd: checkBounds = 1'b1;        // Read-like
      default: ;                                        // Write-like, stack, search
    endcase
  end

  // Fault in priority order
  always_comb begin
    if (request.action == actAlloc && !canAlloc) begin
      fault = errOutOfMemory;
    end else if (checkAlloc && !everIssued) begin
      fault = errNotAllocated;
    end else if (checkAlloc && !allocated) begin
      fault = errFreed;                                 // Also catches double free
    end else if (checkBounds && {1'b0, request.index} >= arraySize) begin
      fault = errOutOfBounds;
    end else if (request.action == actPush && arraySize == FullSize) begin
      fault = errFull;
    end else if (request.action == actPop && arraySize == '0) begin
      fault = errEmpty;
    end else begin
      fault = errNone;
    end
  end

  always_comb begin
    decoded.action  = request.action;
    decoded.arrayId = request.arrayId;
    decoded.index   = request.index;
    decoded.data    = request.data;
    decoded.fault   = fault;
    decoded.commit  = request.action != actIdle && fault == errNone;
    decoded.size    = arraySize;
  end

endmodule

`default_nettype wire

// ==== dv/arrayHeapModel.svh ====
// ----------------------------------------
// Reference model of the array heap
// Included inside the testbench module to
// predict done, error and data
// ----------------------------------------
`ifndef ARRAY_HEAP_MODEL_SVH
`define ARRAY_HEAP_MODEL_SVH

int        modelSize [`HEAP_ARRAYS];
bit        modelLive [`HEAP_ARRAYS];                // Allocated right now
int        modelFresh;                              // Arrays handed out since reset
int        modelFreeStack [$];                      // Newest at the back
dataT      modelElem [`HEAP_ARRAYS][`HEAP_LENGTH];  // Survives the Reset action
logic      expDone;
heapErrorT expError;
dataT      expData;

function automatic bit boundsChecked(input actionT act);
  return act inside {actRead, actAdd, actAddAfter, actSubtract, actSubAfter, actShiftLeft,
                     actShiftRight, actNotLogical, actNot, actOr, actXor, actAnd};
endfunction

function automatic dataT arith(input actionT act, input dataT old, input dataT data);
  case (act)
    actAdd, actAddAfter:         return old + data;
    actSubtract, actSubAfter:    return old - data;
    actShiftLeft:                return old << data;   // Whole word as amount
    actShiftRight:               return old >> data;
    actNotLogical:               return (old == '0) ? dataT'(1) : dataT'(0);
    actNot:                      return ~old;
    actOr:                       return old | data;
    actXor:                      return old ^ data;
    default:                     return old & data;
  endcase
endfunction

task automatic modelReset();
  for (int i = 0; i < `HEAP_ARRAYS; i++) begin
    modelSize[i] = 0;
    modelLive[i] = 1'b0;
  end
  modelFresh = 0;
  modelFreeStack.delete();
  expDone  = 1'b0;
  expError = errNone;
  expData  = '0;
endtask

task automatic modelApply(input actionT act, input int id, input int idx, input dataT data);
  heapErrorT fault;
  dataT      old;
  dataT      result;
  bit        hasWord;
  int        pick;
  fault   = errNone;
  hasWord = 1'b1;
  result  = '0;
  expDone = act != actIdle;
  if (act == actIdle) return;                          // Nothing else changes
  if (act == actAlloc) begin
    if (modelFreeStack.size() == 0 && modelFresh == `HEAP_ARRAYS) fault = errOutOfMemory;
  end else if (act != actReset) begin
    if (id >= modelFresh) fault = errNotAllocated;
    else if (!modelLive[id]) fault = errFreed;
    else if (boundsChecked(act) && idx >= modelSize[id]) fault = errOutOfBounds;
    else if (act == actPush && modelSize[id] == `HEAP_LENGTH) fault = errFull;
    else if (act == actPop && modelSize[id] == 0) fault = errEmpty;
  end
  expError = fault;
  if (fault != errNone) return;                        // Data and state held
  old = modelElem[id][idx];
  case (act)
    actReset: begin
      for (int i = 0; i < `HEAP_ARRAYS; i++) begin
        modelLive[i] = 1'b0;
        modelSize[i] = 0;
      end
      modelFresh = 0;
      modelFreeStack.delete();
      hasWord = 1'b0;
    end
    actAlloc: begin
      if (modelFreeStack.size() != 0) pick = modelFreeStack.pop_back();   // LIFO reuse
      else begin
        pick = modelFresh;
        modelFresh++;
      end
      modelLive[pick] = 1'b1;
      modelSize[pick] = 0;
      result = dataT'(pick);
    end
    actFree: begin
      modelFreeStack.push_back(id);
      modelLive[id] = 1'b0;
      hasWord = 1'b0;
    end
    actWrite: begin
      modelElem[id][idx] = data;
      if (idx >= modelSize[id]) modelSize[id] = idx + 1;   // Grows to index plus one
      result = data;
    end
    actRead:  result = old;
    actSize:  result = dataT'(modelSize[id]);
    actIndex: begin
      for (int i = 0; i < modelSize[id]; i++) begin
        if (modelElem[id][i] == data) result = dataT'(i + 1);   // Last match wins
      end
    end
    actLess: begin
      for (int i = 0; i < modelSize[id]; i++) begin
        if (modelElem[id][i] < data) result++;
      end
    end
    actGreater: begin
      for (int i = 0; i < modelSize[id]; i++) begin
        if (modelElem[id][i] > data) result++;
      end
    end
    actPush: begin
      modelElem[id][modelSize[id]] = data;
      modelSize[id]++;
      hasWord = 1'b0;
    end
    actPop: begin
      modelSize[id]--;
      result = modelElem[id][modelSize[id]];           // Top before the pop
    end
    default: begin
      modelElem[id][idx] = arith(act, old, data);
      result = (act == actAddAfter || act == actSubAfter) ? old : modelElem[id][idx];
    end
  endcase
  if (hasWord) expData = result;
endtask

`endif

// ==== dv/arrayHeapTb.sv ====
// ----------------------------------------
// Testbench for the array heap
// Directed phases then seeded random
// requests, checked against the model
// ----------------------------------------
`default_nettype none
`include "arrayHeap_cfg.svh"

module arrayHeapTb import arrayHeapPkg::*; ();

  localparam int Seed          = 46589;
  localparam int ResetCycles   = 3;
  localparam int RandomSteps   = 600;
  localparam int TimeoutCycles = 4000;          // Whole run, in clocks

  logic         clock;
  logic         resetN;
  heapRequestT  request;
  heapResponseT response;
  int           errors;
  int           checks;

  `include "arrayHeapModel.svh"

  arrayHeap dut (
    .clock   (clock),
    .resetN  (resetN),
    .request (request),
    .response(response)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // ----------------------------------------
  // Checks and stimulus helpers
  // ----------------------------------------
  task automatic checkResponse();
    checks++;
    if (response.done !== expDone) begin
      errors++;
      $display("error at %0t: response.done expected %b got %b", $time, expDone, response.done);
    end
    if (response.error !== expError) begin
      errors++;
      $display("error at %0t: response.error expected %0d got %0d", $time, expError,
               response.error);
    end
    if (response.data !== expData) begin
      errors++;
      $display("error at %0t: response.data expected %h got %h", $time, expData, response.data);
    end
  endtask

  // Checks the last response then drives the next request
  task automatic issue(input actionT act, input int id, input int idx, input dataT data);
    @(negedge clock);
    checkResponse();
    request.action  = act;
    request.arrayId = arrayIdT'(id);
    request.index   = indexT'(idx);
    request.data    = data;
    modelApply(act, id, idx, data);
  endtask

  function automatic actionT pickAction();
    int r;
    r = $urandom % 100;
    if (r < 12) return actAlloc;
    if (r < 17) return actFree;
    if (r < 30) return actWrite;
    if (r < 38) return actRead;
    if (r < 42) return actSize;
    if (r < 52) return actPush;
    if (r < 58) return actPop;
    if (r < 80) return actionT'(int'(actAdd) + int'($urandom % 11));     // Arithmetic codes
    if (r < 95) return actionT'(int'(actIndex) + int'($urandom % 3));    // Search codes
    if (r < 98) return actIdle;
    return actReset;
  endfunction

  function automatic int pickArray();
    int live [$];
    for (int i = 0; i < `HEAP_ARRAYS; i++) begin
      if (modelLive[i]) live.push_back(i);
    end
    if (live.size() != 0 && $urandom % 10 < 8) return live[$urandom % live.size()];
    return $urandom % `HEAP_ARRAYS;
  endfunction

  function automatic int pickIndex(input int id);
    if (modelSize[id] > 0 && $urandom % 10 < 8) return $urandom % modelSize[id];
    return $urandom % `HEAP_LENGTH;
  endfunction

  function automatic dataT pickData(input actionT act, input int id);
    if (act == actShiftLeft || act == actShiftRight) return dataT'($urandom % 20);
    if (act inside {actIndex, actLess, actGreater} && $urandom % 2 == 0) begin
      return modelElem[id][$urandom % `HEAP_LENGTH];  // Likely match
    end
    return dataT'($urandom);
  endfunction

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin : stimulus
    actionT act;
    int     id;
    void'($urandom(Seed));
    request = '0;
    resetN  = 1'b0;
    errors  = 0;
    checks  = 0;
    modelReset();
    for (int k = 0; k < ResetCycles; k++) @(posedge clock);
    @(negedge clock);
    resetN = 1'b1;
    for (int i = 0; i < `HEAP_ARRAYS; i++) begin    // Nothing allocated yet
      issue(actRead, i, 0, '0);
      issue(actFree, i, 0, '0);
      issue(actSize, i, 0, '0);
    end
    for (int k = 0; k <= `HEAP_ARRAYS; k++) issue(actAlloc, 0, 0, '0);   // Last one runs out
    for (int i = 0; i < `HEAP_ARRAYS; i++) begin    // Known contents everywhere
      for (int k = 0; k < `HEAP_LENGTH; k++) issue(actWrite, i, k, dataT'($urandom));
    end
    issue(actFree, 3, 0, '0);
    issue(actFree, 5, 0, '0);
    issue(actFree, 5, 0, '0);                       // Double free
    issue(actAlloc, 0, 0, '0);
    issue(actAlloc, 0, 0, '0);
    issue(actAlloc, 0, 0, '0);
    issue(actReset, 0, 0, '0);
    issue(actRead, 0, 0, '0);
    issue(actAlloc, 0, 0, '0);
    issue(actAlloc, 0, 0, '0);
    issue(actWrite, 0, 5, dataT'($urandom));        // Size grows to six
    issue(actSize, 0, 0, '0);
    issue(actRead, 0, 7, '0);
    issue(actRead, 0, 2, '0);
    for (int k = 0; k <= `HEAP_LENGTH; k++) issue(actPush, 1, 0, dataT'($urandom));
    for (int k = 0; k <= `HEAP_LENGTH; k++) issue(actPop, 1, 0, '0);
    for (int n = 0; n < RandomSteps; n++) begin
      act = pickAction();
      id  = pickArray();
      issue(act, id, pickIndex(id), pickData(act, id));
    end
    issue(actIdle, 0, 0, '0);
    issue(actIdle, 0, 0, '0);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < TimeoutCycles) begin
      @(posedge clock);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d clocks", TimeoutCycles);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== execute/arraySearch.sv ====
// --------------------------------------
// Row scan for Index, Less and Greater
// Only positions below the size count
// --------------------------------------
`default_nettype none
`include "arrayHeap_cfg.svh"

module arraySearch import arrayHeapPkg::*; (
  input  decodedT decoded,
  input  rowT     row,
  output dataT    found
);

  dataT matchPos;                                 // Last match plus one
  dataT count;                                    // Elements below or above
  logic below;                                    // Less, not Greater

  assign below = decoded.action == actLess;

  always_comb begin
    matchPos = '0;
    count    = '0;
    for (int i = 0; i < `HEAP_LENGTH; i++) begin
      if (i < int'(decoded.size)) begin
        if (row[i] == decoded.data) matchPos = dataT'(i + 1);
        if (below ? row[i] < decoded.data : row[i] > decoded.data) begin
          count = count + 1'b1;
        end
      end
    end
  end

  assign found = decoded.action == actIndex ? matchPos : count;

endmodule

`default_nettype wire

// ==== execute/elementAlu.sv ====
// --------------------------------------
// Element arithmetic
// New element value for writes and the
// word returned to the requester
// --------------------------------------
`default_nettype none

module elementAlu import arrayHeapPkg::*; (
  input  decodedT decoded,
  input  rowT     row,
  output logic    writeEnable,
  output indexT   writeIndex,
  output dataT    writeData,
  output dataT    returned
);

  dataT  element;                                 // Addressed element, old value
  dataT  newValue;
  indexT topIndex;                                // Last used position
  logic  writes;

  assign element  = row[decoded.index];
  assign topIndex = indexT'(decoded.size - 1'b1);

  always_comb begin
    newValue = element;
    writes   = 1'b1;
    case (decoded.action)
      actWrite, actPush:          newValue = decoded.data;
      actAdd, actAddAfter:        newValue = element + decoded.data;
      actSubtract, actSubAfter:   newValue = element - decoded.data;
      actShiftLeft:               newValue = element << decoded.data;   // Whole word as amount
      actShiftRight:              newValue = element >> decoded.data;
      actNotLogical:              newValue = dataT'(element == '0);
      actNot:                     newValue = ~element;
      actOr:                      newValue = element | decoded.data;
      actXor:                     newValue = element ^ decoded.data;
      actAnd:                     newValue = element & decoded.data;
      default:                    writes   = 1'b0;
    endcase
  end

  assign writeEnable = decoded.commit && writes;
  assign writeIndex  = decoded.action == actPush ? decoded.size[$bits(indexT)-1:0]
                                                 : decoded.index;   // Push appends
  assign writeData   = newValue;

  // Returned word
  always_comb begin
    case (decoded.action)
      actRead, actAddAfter, actSubAfter: returned = element;        // Old value
      actPop:                            returned = row[topIndex];
      default:                           returned = newValue;
    endcase
  end

endmodule

`default_nettype wire

// ==== execute/elementStore.sv ====
// --------------------------------------
// Element registers
// One write port, whole row read of the
// named array
// --------------------------------------
`default_nettype none
`include "arrayHeap_cfg.svh"

module elementStore import arrayHeapPkg::*; (
  input  logic    clock,
  input  arrayIdT readId,
  output rowT     row,
  input  logic    writeEnable,
  input  arrayIdT writeId,
  input  indexT   writeIndex,
  input  dataT    writeData
);

  rowT memory [`HEAP_ARRAYS];                     // One row per array

  // --------------------------------------
  // Read
  // --------------------------------------
  assign row = memory[readId];                    // Combinational, same cycle

  // --------------------------------------
  // Write
  // --------------------------------------
  // Contents survive the Reset action, only sizes are cleared
  always_ff @(posedge clock) begin
    if (writeEnable) begin
      memory[writeId][writeIndex] <= writeData;
    end
  end

endmodule

`default_nettype wire

// ==== logic/arrayHeap.sv ====
// --------------------------------------
// Array heap top level
// One request per clock, response one
// cycle later
// --------------------------------------
`default_nettype none

module arrayHeap import arrayHeapPkg::*; (
  input  logic         clock,
  input  logic         resetN,
  input  heapRequestT  request,
  output heapResponseT response
);

  sizeT    arraySize;                             // Size of the named array
  logic    allocated;
  logic    everIssued;
  logic    canAlloc;
  arrayIdT allocId;                               // Array for the current Alloc
  decodedT decoded;
  rowT     row;                                   // Named array contents
  logic    writeEnable;
  indexT   writeIndex;
  dataT    writeData;
  dataT    returned;                              // ALU result
  dataT    found;                                 // Search result

  // --------------------------------------
  // Decode
  // --------------------------------------
  requestDecode decode (
    .request   (request),
    .arraySize (arraySize),
    .allocated (allocated),
    .everIssued(everIssued),
    .canAlloc  (canAlloc),
    .decoded   (decoded)
  );

  arrayDirectory directory (
    .clock     (clock),
    .resetN    (resetN),
    .lookupId  (request.arrayId),
    .decoded   (decoded),
    .arraySize (arraySize),
    .allocated (allocated),
    .everIssued(everIssued),
    .canAlloc  (canAlloc),
    .allocId   (allocId)
  );

  // --------------------------------------
  // Execute
  // --------------------------------------
  elementStore store (
    .clock      (clock),
    .readId     (request.arrayId),
    .row        (row),
    .writeEnable(writeEnable),
    .writeId    (decoded.arrayId),
    .writeIndex (writeIndex),
    .writeData  (writeData)
  );

  elementAlu alu (
    .decoded    (decoded),
    .row        (row),
    .writeEnable(writeEnable),
    .writeIndex (writeIndex),
    .writeData  (writeData),
    .returned   (returned)
  );

  arraySearch search (
    .decoded(decoded),
    .row    (row),
    .found  (found)
  );

  // --------------------------------------
  // Result
  // --------------------------------------
  resultStage result (
    .clock   (clock),
    .resetN  (resetN),
    .decoded (decoded),
    .returned(returned),
    .found   (found),
    .allocId (allocId),
    .response(response)
  );

endmodule

`default_nettype wire

// ==== result/resultStage.sv ====
// --------------------------------------
// Response register
// Picks the returned word and holds it
// with done and the error code
// --------------------------------------
`default_nettype none

module resultStage import arrayHeapPkg::*; (
  input  logic         clock,
  input  logic         resetN,
  input  decodedT      decoded,
  input  dataT         returned,
  input  dataT         found,
  input  arrayIdT      allocId,
  output heapResponseT response
);

  dataT word;                                     // Returned word
  logic hasWord;                                  // Action returns something

  always_comb begin
    hasWord = 1'b1;
    case (decoded.action)
      actAlloc:                      word = dataT'(allocId);
      actSize:                       word = dataT'(decoded.size);
      actIndex, actLess, actGreater: word = found;
      default:                       word = returned;
    endcase
    case (decoded.action)
      actIdle, actReset, actFree, actPush: hasWord = 1'b0;
      default: ;
    endcase
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      response.done  <= 1'b0;
      response.data  <= '0;
      response.error <= errNone;
    end else begin
      response.done <= decoded.action != actIdle;   // Also on a fault
      if (decoded.action != actIdle) response.error <= decoded.fault;
      if (decoded.commit && hasWord) response.data <= word;   // Held on a fault
    end
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build the array heap testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f arrayHeap.f --top-module arrayHeapTb -o arrayHeapSim

output=$(./obj_dir/arrayHeapSim)
echo "$output"

if echo "$output" | grep -q "TESTBENCH PASSED"; then
  exit 0
fi
exit 1
